// ==== i3c_defines.svh ====
// Width, synchronizer depth and encoding macros for the I3C target core
`ifndef I3C_DEFINES_SVH
`define I3C_DEFINES_SVH

// Byte and address widths
`define I3C_DATA_W 8
`define I3C_ADDR_W 7

// SCL/SDA input synchronizer depth
`define I3C_SYNC_STAGES 2

// Sent when the TX queue runs dry during a read
`define I3C_IDLE_BYTE 8'hFF

// R/W bit of the address byte
`define I3C_RNW_READ 1'b1

`endif

// ==== i3c_pkg.sv ====
// Address byte types and target FSM state encoding
`default_nettype none

`include "i3c_defines.svh"

package i3c_pkg;

  // Address in the upper bits, R/W bit in the LSB
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] addr;
    logic                   rnw;
  } addr_fields_t;

  typedef union packed {
    logic [`I3C_DATA_W-1:0] raw;
    addr_fields_t           fields;
  } addr_byte_u;

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_addr_ack,
    st_wr_byte,
    st_wr_tbit,
    st_rd_byte,
    st_rd_tbit,
    st_wait
  } tgt_state_e;

endpackage

`default_nettype wire

// ==== i3c_bus_if.sv ====
// Bus event, bit/byte receive and bit/byte transmit interfaces
`default_nettype none

`include "i3c_defines.svh"

interface bus_event_if;
  logic scl_posedge;
  logic scl_negedge;
  logic start_det;
  logic rstart_det;
  logic stop_det;

  modport source (output scl_posedge, scl_negedge, start_det, rstart_det, stop_det);
  modport sink (input scl_posedge, scl_negedge, start_det, rstart_det, stop_det);
endinterface

interface bus_rx_if;
  logic                   req_bit;
  logic                   req_byte;
  logic                   done;
  logic [`I3C_DATA_W-1:0] data;

  modport requester (output req_bit, req_byte, input done, data);
  modport responder (input req_bit, req_byte, output done, data);
endinterface

interface bus_tx_if;
  logic                   req_bit;
  logic                   req_byte;
  logic [`I3C_DATA_W-1:0] value;
  logic                   sel_od_pp;
  logic                   done;

  modport requester (output req_bit, req_byte, value, sel_od_pp, input done);
  modport responder (input req_bit, req_byte, value, sel_od_pp, output done);
endinterface

`default_nettype wire

// ==== bus_monitor.sv ====
// SCL/SDA synchronizer, SCL edge detection and START, repeated START and STOP detection
`default_nettype none

`include "i3c_defines.svh"

module bus_monitor (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        sda_sync_o,
  bus_event_if.source ev
);

  localparam int unsigned n_sync = `I3C_SYNC_STAGES;

  logic [n_sync-1:0] scl_sync;
  logic [n_sync-1:0] sda_sync;
  logic              scl_s;
  logic              sda_s;
  logic              scl_q;
  logic              sda_q;
  logic              in_xfer;
  logic              scl_high;
  logic              sda_fall;
  logic              sda_rise;

  assign scl_s = scl_sync[n_sync-1];
  assign sda_s = sda_sync[n_sync-1];

  // SDA may only move with SCL high for a bus condition
  assign scl_high = scl_s & scl_q;
  assign sda_fall = sda_q & ~sda_s;
  assign sda_rise = ~sda_q & sda_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync       <= '1;
      sda_sync       <= '1;
      scl_q          <= 1'b1;
      sda_q          <= 1'b1;
      in_xfer        <= 1'b0;
      ev.scl_posedge <= 1'b0;
      ev.scl_negedge <= 1'b0;
      ev.start_det   <= 1'b0;
      ev.rstart_det  <= 1'b0;
      ev.stop_det    <= 1'b0;
    end else begin
      scl_sync       <= {scl_sync[n_sync-2:0], scl_i};
      sda_sync       <= {sda_sync[n_sync-2:0], sda_i};
      scl_q          <= scl_s;
      sda_q          <= sda_s;
      ev.scl_posedge <= scl_s & ~scl_q;
      ev.scl_negedge <= ~scl_s & scl_q;
      ev.start_det   <= scl_high & sda_fall & ~in_xfer;
      ev.rstart_det  <= scl_high & sda_fall & in_xfer;
      ev.stop_det    <= scl_high & sda_rise;
      if (scl_high && sda_fall) begin
        in_xfer <= 1'b1;
      end else if (scl_high && sda_rise) begin
        in_xfer <= 1'b0;
      end
    end
  end

  // Aligned with the edge pulses
  assign sda_sync_o = sda_q;

endmodule

`default_nettype wire

// ==== bus_rx_flow.sv ====
// SDA shifter that samples a bit or a byte on SCL rising edges
`default_nettype none

`include "i3c_defines.svh"

module bus_rx_flow (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         sda_i,
  bus_event_if.sink    ev,
  bus_rx_if.responder  rx
);

  localparam int unsigned cnt_w = $clog2(`I3C_DATA_W);

  logic [cnt_w-1:0]       bit_cnt;
  logic [`I3C_DATA_W-1:0] shift_q;
  logic                   sample;
  logic                   last_bit;

  assign sample   = (rx.req_bit | rx.req_byte) & ev.scl_posedge;
  assign last_bit = rx.req_bit | (bit_cnt == cnt_w'(`I3C_DATA_W - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt <= '0;
      rx.done <= 1'b0;
    end else begin
      rx.done <= 1'b0;
      // Any bus condition restarts the framing
      if (ev.start_det || ev.rstart_det || ev.stop_det) begin
        bit_cnt <= '0;
      end else if (sample) begin
        if (last_bit) begin
          bit_cnt <= '0;
          rx.done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // MSB first, a single bit lands in the LSB
  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[`I3C_DATA_W-2:0], sda_i};
    end
  end

  assign rx.data = shift_q;

endmodule

`default_nettype wire

// ==== target_fsm.sv ====
// Transfer FSM for address match, ACK/NACK, write parity check and read T bit
`default_nettype none

`include "i3c_defines.svh"

module target_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  bus_event_if.sink              ev,
  bus_rx_if.requester            rx,
  bus_tx_if.requester            tx,
  input  logic [`I3C_ADDR_W-1:0] target_addr_i,
  input  logic                   target_addr_valid_i,
  input  logic                   rx_full_i,
  output logic                   rx_wvalid_o,
  output logic [`I3C_DATA_W-1:0] rx_wdata_o,
  input  logic                   tx_rvalid_i,
  output logic                   tx_rready_o,
  input  logic [`I3C_DATA_W-1:0] tx_rdata_i,
  output i3c_pkg::addr_byte_u    bus_addr_o,
  output logic                   bus_addr_valid_o,
  output logic                   parity_err_o
);

  i3c_pkg::tgt_state_e    state;
  i3c_pkg::addr_byte_u    rx_addr;
  logic                   is_read;
  logic                   ack_ok;
  logic                   ack_q;
  logic                   rd_q;
  logic                   tbit_q;
  logic                   parity_ok;
  logic                   pop;
  logic [`I3C_DATA_W-1:0] wr_byte_q;
  logic [`I3C_DATA_W-1:0] rd_byte_q;

  // Same byte seen raw and as address/direction fields
  always_comb begin
    rx_addr.raw = rx.data;
  end

  assign is_read = (rx_addr.fields.rnw == `I3C_RNW_READ);

  // Own address and room in the queue for that direction
  assign ack_ok = target_addr_valid_i && (rx_addr.fields.addr == target_addr_i) &&
                  (is_read ? tx_rvalid_i : !rx_full_i);

  // Odd parity over data byte plus T bit
  assign parity_ok = ^{wr_byte_q, rx.data[0]};

  // Next read byte is fetched when the ACK or a T bit of 1 completes
  assign pop = tx.done && (((state == i3c_pkg::st_addr_ack) && ack_q && rd_q) ||
                           ((state == i3c_pkg::st_rd_tbit) && tbit_q));
  assign tx_rready_o = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state            <= i3c_pkg::st_idle;
      ack_q            <= 1'b0;
      rd_q             <= 1'b0;
      tbit_q           <= 1'b0;
      rx_wvalid_o      <= 1'b0;
      parity_err_o     <= 1'b0;
      bus_addr_valid_o <= 1'b0;
    end else begin
      rx_wvalid_o      <= 1'b0;
      parity_err_o     <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      if (ev.start_det || ev.rstart_det) begin
        state <= i3c_pkg::st_addr;
      end else if (ev.stop_det) begin
        state <= i3c_pkg::st_idle;
      end else begin
        case (state)
          i3c_pkg::st_addr: begin
            if (rx.done) begin
              bus_addr_valid_o <= 1'b1;
              ack_q            <= ack_ok;
              rd_q             <= is_read;
              state            <= i3c_pkg::st_addr_ack;
            end
          end
          i3c_pkg::st_addr_ack: begin
            if (tx.done) begin
              if (!ack_q) begin
                state <= i3c_pkg::st_wait;
              end else if (rd_q) begin
                state <= i3c_pkg::st_rd_byte;
              end else begin
                state <= i3c_pkg::st_wr_byte;
              end
            end
          end
          i3c_pkg::st_wr_byte: begin
            if (rx.done) begin
              state <= i3c_pkg::st_wr_tbit;
            end
          end
          i3c_pkg::st_wr_tbit: begin
            if (rx.done) begin
              rx_wvalid_o  <= parity_ok;
              parity_err_o <= !parity_ok;
              state        <= i3c_pkg::st_wr_byte;
            end
          end
          i3c_pkg::st_rd_byte: begin
            if (tx.done) begin
              tbit_q <= tx_rvalid_i;
              state  <= i3c_pkg::st_rd_tbit;
            end
          end
          i3c_pkg::st_rd_tbit: begin
            if (tx.done) begin
              state <= tbit_q ? i3c_pkg::st_rd_byte : i3c_pkg::st_wait;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == i3c_pkg::st_addr) && rx.done) begin
      bus_addr_o <= rx_addr;
    end
    if ((state == i3c_pkg::st_wr_byte) && rx.done) begin
      wr_byte_q <= rx.data;
    end
    if (pop) begin
      rd_byte_q <= tx_rvalid_i ? tx_rdata_i : `I3C_IDLE_BYTE;
    end
  end

  assign rx_wdata_o = wr_byte_q;

  always_comb begin
    rx.req_bit   = 1'b0;
    rx.req_byte  = 1'b0;
    tx.req_bit   = 1'b0;
    tx.req_byte  = 1'b0;
    tx.value     = '0;
    tx.sel_od_pp = 1'b0;
    case (state)
      i3c_pkg::st_addr,
      i3c_pkg::st_wr_byte: rx.req_byte = 1'b1;
      i3c_pkg::st_wr_tbit: rx.req_bit = 1'b1;
      i3c_pkg::st_addr_ack: begin
        // ACK pulls SDA low in open-drain mode
        tx.req_bit = 1'b1;
        tx.value   = {{(`I3C_DATA_W-1){1'b0}}, !ack_q};
      end
      i3c_pkg::st_rd_byte: begin
        tx.req_byte  = 1'b1;
        tx.value     = rd_byte_q;
        tx.sel_od_pp = 1'b1;
      end
      i3c_pkg::st_rd_tbit: begin
        tx.req_bit   = 1'b1;
        tx.value     = {{(`I3C_DATA_W-1){1'b0}}, tbit_q};
        tx.sel_od_pp = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== bus_tx_flow.sv ====
// SDA driver that shifts a bit or a byte out on SCL falling edges and selects the pad mode
`default_nettype none

`include "i3c_defines.svh"

module bus_tx_flow (
  input  logic         clk_i,
  input  logic         rst_ni,
  bus_event_if.sink    ev,
  bus_tx_if.responder  tx,
  output logic         sda_o,
  output logic         sel_od_pp_o
);

  localparam int unsigned cnt_w = $clog2(`I3C_DATA_W);

  logic                   active;
  logic                   scl_low_q;
  logic [cnt_w-1:0]       bits_left;
  logic [`I3C_DATA_W-1:0] shift_q;
  logic                   load;

  // A request made while SCL is already low goes out at once
  assign load    = !active && (tx.req_bit || tx.req_byte) && (ev.scl_negedge || scl_low_q);
  assign tx.done = active && ev.scl_negedge && (bits_left == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active      <= 1'b0;
      scl_low_q   <= 1'b0;
      bits_left   <= '0;
      sda_o       <= 1'b1;
      sel_od_pp_o <= 1'b0;
    end else begin
      if (ev.scl_negedge) begin
        scl_low_q <= 1'b1;
      end else if (ev.scl_posedge) begin
        scl_low_q <= 1'b0;
      end
      if (ev.start_det || ev.rstart_det || ev.stop_det || tx.done) begin
        active      <= 1'b0;
        sda_o       <= 1'b1;
        sel_od_pp_o <= 1'b0;
      end else if (load) begin
        active      <= 1'b1;
        sel_od_pp_o <= tx.sel_od_pp;
        sda_o       <= tx.req_bit ? tx.value[0] : tx.value[`I3C_DATA_W-1];
        bits_left   <= tx.req_bit ? '0 : cnt_w'(`I3C_DATA_W - 1);
      end else if (active && ev.scl_negedge) begin
        bits_left <= bits_left - 1'b1;
        sda_o     <= shift_q[`I3C_DATA_W-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= {tx.value[`I3C_DATA_W-2:0], 1'b0};
    end else if (active && ev.scl_negedge) begin
      shift_q <= {shift_q[`I3C_DATA_W-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== i3c_target_top.sv ====
// Top level of the I3C SDR target core with bus monitor, RX/TX flows and FSM
`default_nettype none

`include "i3c_defines.svh"

module i3c_target_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_scl_i,
  input  logic                   ctrl_sda_i,
  output logic                   ctrl_sda_o,
  output logic                   phy_sel_od_pp_o,
  input  logic [`I3C_ADDR_W-1:0] target_addr_i,
  input  logic                   target_addr_valid_i,
  output logic                   rx_wvalid_o,
  output logic [`I3C_DATA_W-1:0] rx_wdata_o,
  input  logic                   rx_full_i,
  input  logic                   tx_rvalid_i,
  output logic                   tx_rready_o,
  input  logic [`I3C_DATA_W-1:0] tx_rdata_i,
  output logic                   bus_start_o,
  output logic                   bus_rstart_o,
  output logic                   bus_stop_o,
  output i3c_pkg::addr_byte_u    bus_addr_o,
  output logic                   bus_addr_valid_o,
  output logic                   parity_err_o
);

  logic sda_sync;

  bus_event_if ev_if ();
  bus_rx_if    rx_if ();
  bus_tx_if    tx_if ();

  bus_monitor i_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i      (ctrl_scl_i),
    .sda_i      (ctrl_sda_i),
    .sda_sync_o (sda_sync),
    .ev         (ev_if.source)
  );

  bus_rx_flow i_bus_rx_flow (
    .clk_i,
    .rst_ni,
    .sda_i (sda_sync),
    .ev    (ev_if.sink),
    .rx    (rx_if.responder)
  );

  target_fsm i_target_fsm (
    .clk_i,
    .rst_ni,
    .ev  (ev_if.sink),
    .rx  (rx_if.requester),
    .tx  (tx_if.requester),
    .target_addr_i,
    .target_addr_valid_i,
    .rx_full_i,
    .rx_wvalid_o,
    .rx_wdata_o,
    .tx_rvalid_i,
    .tx_rready_o,
    .tx_rdata_i,
    .bus_addr_o,
    .bus_addr_valid_o,
    .parity_err_o
  );

  bus_tx_flow i_bus_tx_flow (
    .clk_i,
    .rst_ni,
    .ev          (ev_if.sink),
    .tx          (tx_if.responder),
    .sda_o       (ctrl_sda_o),
    .sel_od_pp_o (phy_sel_od_pp_o)
  );

  assign bus_start_o  = ev_if.start_det;
  assign bus_rstart_o = ev_if.rstart_det;
  assign bus_stop_o   = ev_if.stop_det;

endmodule

`default_nettype wire

// ==== i3c_target_props.sv ====
// Concurrent assertions on the I3C target top-level ports and their bind
`default_nettype none

module i3c_target_props (
  input logic clk_i,
  input logic rst_ni,
  input logic ctrl_sda_o,
  input logic phy_sel_od_pp_o,
  input logic rx_wvalid_o,
  input logic parity_err_o,
  input logic tx_rready_o,
  input logic tx_rvalid_i,
  input logic bus_start_o,
  input logic bus_rstart_o,
  input logic bus_stop_o,
  input logic bus_addr_valid_o
);

  logic ack_win;
  logic sda_q;

  // Open from the address byte until the target first releases SDA
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_win <= 1'b0;
      sda_q   <= 1'b1;
    end else begin
      sda_q <= ctrl_sda_o;
      if (bus_addr_valid_o) begin
        ack_win <= 1'b1;
      end else if ((ctrl_sda_o && !sda_q) || bus_start_o || bus_rstart_o || bus_stop_o) begin
        ack_win <= 1'b0;
      end
    end
  end

  a_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_wvalid_o && parity_err_o))
    else $error("write strobe and parity error in the same cycle");

  a_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_rready_o |-> tx_rvalid_i)
    else $error("TX ready without TX valid");

  a_ack_od: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_win && !ctrl_sda_o) |-> !phy_sel_od_pp_o)
    else $error("ACK driven push-pull");

  a_start_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_start_o |=> !bus_start_o)
    else $error("START event longer than one cycle");

  a_rstart_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rstart_o |=> !bus_rstart_o)
    else $error("repeated START event longer than one cycle");

  a_stop_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stop_o |=> !bus_stop_o)
    else $error("STOP event longer than one cycle");

endmodule

bind i3c_target_top i3c_target_props i_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .ctrl_sda_o       (ctrl_sda_o),
  .phy_sel_od_pp_o  (phy_sel_od_pp_o),
  .rx_wvalid_o      (rx_wvalid_o),
  .parity_err_o     (parity_err_o),
  .tx_rready_o      (tx_rready_o),
  .tx_rvalid_i      (tx_rvalid_i),
  .bus_start_o      (bus_start_o),
  .bus_rstart_o     (bus_rstart_o),
  .bus_stop_o       (bus_stop_o),
  .bus_addr_valid_o (bus_addr_valid_o)
);

`default_nettype wire

// ==== tb_i3c_target.sv ====
// Testbench for the I3C target core with a bus controller model, transfer table and TX queue model
`default_nettype none

`include "i3c_defines.svh"

module tb_i3c_target;

  localparam int n_rows = 8;
  localparam int half_cyc = 8;
  localparam int quarter_cyc = 4;
  localparam int cond_timeout = 64;
  localparam logic [`I3C_ADDR_W-1:0] own_addr = 7'h2A;

  // One transfer with address, direction, byte count, bad T bit on byte 0, RSTART and ACK
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] addr;
    logic                   rnw;
    logic [3:0]             nbytes;
    logic                   bad_par;
    logic                   rstart;
    logic                   ack;
  } xfer_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   ctrl_scl;
  logic                   ctrl_sda;
  logic                   bus_sda;
  logic                   ctrl_sda_o;
  logic                   phy_sel_od_pp_o;
  logic [`I3C_ADDR_W-1:0] target_addr_i;
  logic                   target_addr_valid_i;
  logic                   rx_wvalid_o;
  logic [`I3C_DATA_W-1:0] rx_wdata_o;
  logic                   rx_full_i;
  logic                   tx_rvalid_i;
  logic                   tx_rready_o;
  logic [`I3C_DATA_W-1:0] tx_rdata_i;
  logic                   bus_start_o;
  logic                   bus_rstart_o;
  logic                   bus_stop_o;
  i3c_pkg::addr_byte_u    bus_addr_o;
  logic                   bus_addr_valid_o;
  logic                   parity_err_o;

  xfer_t                  xfers [n_rows];
  logic [`I3C_DATA_W-1:0] tx_q[$];
  logic [`I3C_DATA_W-1:0] exp_q[$];
  logic [`I3C_DATA_W-1:0] rx_log[$];
  logic [`I3C_DATA_W-1:0] addr_log[$];
  int                     parity_cnt;
  int                     start_cnt;
  int                     rstart_cnt;
  int                     stop_cnt;
  int                     err_cnt;
  int                     check_cnt;
  int                     seed;
  logic                   pop_pend;
  logic                   prev_rstart;
  logic                   timed_out;

  // Open-drain wired AND of controller and target
  assign bus_sda = ctrl_sda & ctrl_sda_o;

  i3c_target_top i_dut (
    .clk_i,
    .rst_ni,
    .ctrl_scl_i (ctrl_scl),
    .ctrl_sda_i (bus_sda),
    .ctrl_sda_o,
    .phy_sel_od_pp_o,
    .target_addr_i,
    .target_addr_valid_i,
    .rx_wvalid_o,
    .rx_wdata_o,
    .rx_full_i,
    .tx_rvalid_i,
    .tx_rready_o,
    .tx_rdata_i,
    .bus_start_o,
    .bus_rstart_o,
    .bus_stop_o,
    .bus_addr_o,
    .bus_addr_valid_o,
    .parity_err_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Output log sampled mid-cycle
  always @(negedge clk_i) begin
    if (rx_wvalid_o) rx_log.push_back(rx_wdata_o);
    if (bus_addr_valid_o) addr_log.push_back(bus_addr_o.raw);
    if (parity_err_o) parity_cnt++;
    if (bus_start_o) start_cnt++;
    if (bus_rstart_o) rstart_cnt++;
    if (bus_stop_o) stop_cnt++;
  end

  // TX queue model whose pop lands one falling edge after the handshake cycle
  always @(negedge clk_i) begin
    logic pend_now;
    pend_now = tx_rready_o && tx_rvalid_i;
    if (pop_pend) void'(tx_q.pop_front());
    pop_pend    = pend_now;
    tx_rvalid_i = (tx_q.size() != 0);
    tx_rdata_i  = (tx_q.size() != 0) ? tx_q[0] : '0;
  end

  task automatic check_value(input string what, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      $display("[ERROR] %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // One SCL period with SDA sampled late in the high phase
  task automatic clock_bit(input logic b, output logic s);
    wait_cycles(quarter_cyc);
    ctrl_sda = b;
    wait_cycles(quarter_cyc);
    ctrl_scl = 1'b1;
    wait_cycles(half_cyc - 2);
    s = bus_sda;
    wait_cycles(2);
    ctrl_scl = 1'b0;
  endtask

  task automatic send_start();
    ctrl_sda = 1'b0;
    wait_cycles(half_cyc);
    ctrl_scl = 1'b0;
  endtask

  task automatic send_stop();
    wait_cycles(quarter_cyc);
    ctrl_sda = 1'b0;
    wait_cycles(quarter_cyc);
    ctrl_scl = 1'b1;
    wait_cycles(half_cyc);
    ctrl_sda = 1'b1;
    wait_cycles(half_cyc);
  endtask

  task automatic send_rstart();
    wait_cycles(quarter_cyc);
    ctrl_sda = 1'b1;
    wait_cycles(quarter_cyc);
    ctrl_scl = 1'b1;
    wait_cycles(half_cyc);
    ctrl_sda = 1'b0;
    wait_cycles(half_cyc);
    ctrl_scl = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] d, input logic tbit);
    logic s;
    for (int k = 7; k >= 0; k--) begin
      clock_bit(d[k], s);
    end
    clock_bit(tbit, s);
  endtask

  // Read data and T bit are driven push-pull
  task automatic read_byte(output logic [7:0] d, output logic t);
    logic s;
    for (int k = 7; k >= 0; k--) begin
      clock_bit(1'b1, s);
      d[k] = s;
      check_value("read pad mode", int'(phy_sel_od_pp_o), 1);
    end
    clock_bit(1'b1, t);
    check_value("T bit pad mode", int'(phy_sel_od_pp_o), 1);
  endtask

  task automatic send_addr(input logic [7:0] a, output logic ack);
    logic s;
    for (int k = 7; k >= 0; k--) begin
      clock_bit(a[k], s);
    end
    clock_bit(1'b1, s);
    ack = !s;
  endtask

  // Polls the event counts until STOP or RSTART shows up
  task automatic wait_bus_cond(input logic is_stop);
    int n;
    for (n = 0; n < cond_timeout; n++) begin
      if ((is_stop && stop_cnt > 0) || (!is_stop && rstart_cnt > 0)) break;
      @(negedge clk_i);
    end
    if (n == cond_timeout) begin
      $display("Timeout: the target reported no %s", is_stop ? "STOP" : "repeated START");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_row(input int i);
    xfer_t               x;
    i3c_pkg::addr_byte_u ab;
    logic                ack;
    logic                t;
    logic [7:0]          d;
    int                  rnd;
    int                  errs_before;
    int                  n_wr;
    x           = xfers[i];
    errs_before = err_cnt;
    rx_log.delete();
    addr_log.delete();
    exp_q.delete();
    parity_cnt = 0;
    start_cnt  = 0;
    rstart_cnt = 0;
    stop_cnt   = 0;
    rx_full_i  = (x.addr == own_addr) && !x.rnw && !x.ack;
    if (x.rnw && x.ack) begin
      for (int j = 0; j < int'(x.nbytes); j++) begin
        rnd = $random(seed);
        tx_q.push_back(rnd[7:0]);
        exp_q.push_back(rnd[7:0]);
      end
    end
    if (!prev_rstart) send_start();
    ab.fields.addr = x.addr;
    ab.fields.rnw  = x.rnw;
    send_addr(ab.raw, ack);
    check_value("ACK", int'(ack), int'(x.ack));
    if (ack && x.ack) begin
      for (int j = 0; j < int'(x.nbytes); j++) begin
        if (!x.rnw) begin
          rnd = $random(seed);
          d   = rnd[7:0];
          // T bit makes the nine bits odd unless corrupted
          t   = (j == 0 && x.bad_par) ? ^d : ~^d;
          write_byte(d, t);
          if (!(j == 0 && x.bad_par)) exp_q.push_back(d);
        end else begin
          read_byte(d, t);
          check_value("read byte", int'(d), int'(exp_q[j]));
          check_value("T bit", int'(t), int'(j < int'(x.nbytes) - 1));
        end
      end
    end
    if (x.rstart) begin
      send_rstart();
      wait_bus_cond(1'b0);
    end else begin
      send_stop();
      wait_bus_cond(1'b1);
    end
    if (timed_out) return;
    rx_full_i = 1'b0;
    check_value("START count", start_cnt, int'(!prev_rstart));
    check_value("RSTART count", rstart_cnt, int'(x.rstart));
    check_value("STOP count", stop_cnt, int'(!x.rstart));
    check_value("address pulses", addr_log.size(), 1);
    if (addr_log.size() != 0) check_value("bus address", int'(addr_log[0]), int'(ab.raw));
    check_value("parity errors", parity_cnt,
                int'(!x.rnw && x.ack && x.bad_par && x.nbytes != 0));
    n_wr = x.rnw ? 0 : exp_q.size();
    check_value("write count", rx_log.size(), n_wr);
    for (int j = 0; j < n_wr && j < rx_log.size(); j++) begin
      check_value("write byte", int'(rx_log[j]), int'(exp_q[j]));
    end
    if (x.rnw) check_value("TX queue left", tx_q.size(), 0);
    prev_rstart = x.rstart;
    $display("row %0d %s addr 0x%0h %0d bytes: %s", i, x.rnw ? "read" : "write",
             x.addr, x.nbytes, (err_cnt == errs_before) ? "pass" : "fail");
  endtask

  initial begin
    rst_ni              = 1'b0;
    ctrl_scl            = 1'b1;
    ctrl_sda            = 1'b1;
    target_addr_i       = own_addr;
    target_addr_valid_i = 1'b1;
    rx_full_i           = 1'b0;
    tx_rvalid_i         = 1'b0;
    tx_rdata_i          = '0;
    pop_pend            = 1'b0;
    prev_rstart         = 1'b0;
    timed_out           = 1'b0;
    err_cnt             = 0;
    check_cnt           = 0;
    seed                = 53;

    xfers[0] = '{own_addr, 1'b0, 4'd3, 1'b0, 1'b0, 1'b1};
    xfers[1] = '{own_addr, 1'b0, 4'd2, 1'b1, 1'b0, 1'b1};
    xfers[2] = '{7'h15,    1'b0, 4'd1, 1'b0, 1'b0, 1'b0};
    xfers[3] = '{own_addr, 1'b0, 4'd1, 1'b0, 1'b0, 1'b0};
    xfers[4] = '{own_addr, 1'b1, 4'd3, 1'b0, 1'b0, 1'b1};
    xfers[5] = '{own_addr, 1'b1, 4'd1, 1'b0, 1'b0, 1'b0};
    xfers[6] = '{own_addr, 1'b0, 4'd2, 1'b0, 1'b1, 1'b1};
    xfers[7] = '{own_addr, 1'b1, 4'd2, 1'b0, 1'b0, 1'b1};

    wait_cycles(3);
    rst_ni = 1'b1;
    wait_cycles(2);
    check_value("SDA after reset", int'(ctrl_sda_o), 1);
    check_value("pad mode after reset", int'(phy_sel_od_pp_o), 0);
    check_value("strobes after reset",
                int'({rx_wvalid_o, tx_rready_o, bus_addr_valid_o, parity_err_o,
                      bus_start_o, bus_rstart_o, bus_stop_o}), 0);
    $display("reset: %s", (err_cnt == 0) ? "pass" : "fail");

    for (int i = 0; i < n_rows && !timed_out; i++) begin
      run_row(i);
    end

    $display("%0d rows, %0d checks, %0d errors", n_rows, check_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
i3c_pkg.sv
i3c_bus_if.sv
bus_monitor.sv
bus_rx_flow.sv
target_fsm.sv
bus_tx_flow.sv
i3c_target_top.sv
i3c_target_props.sv
tb_i3c_target.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_i3c_target
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
